/* design/mem_stage_defs.svh */
// memory stage shared widths
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// ********************************************************************
// datapath
// ********************************************************************

`define XLEN            64    // register and data width
`define RAM_ADDR_BITS   8     // word index bits, 256 words of 8 bytes

// ********************************************************************
// instruction fields
// ********************************************************************

`define RD_LSB          7     // rd at [11:7]
`define RS2_LSB         20    // rs2 at [24:20]
`define FUNCT3_LSB      12    // funct3 at [14:12]
`define OPCODE_BITS     7     // opcode at [6:0]

// register specifiers are always 5 bits wide in the base ISA
// funct7 sits at [31:25] and is decoded directly

`endif

/* design/mem_stage_pkg.sv */
// memory stage types and opcodes
`include "mem_stage_defs.svh"

package mem_stage_pkg;

    // ********************************************************************
    // access size, encoded as funct3[1:0] of loads and stores
    // ********************************************************************
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,  // byte
        SIZE_H = 2'd1,  // half
        SIZE_W = 2'd2,  // word
        SIZE_D = 2'd3   // double
    } mem_size_t;

    // ********************************************************************
    // register write-back source
    // ********************************************************************
    typedef enum logic [1:0] {
        WB_NONE = 2'd0, // no rd write (store, branch, unknown)
        WB_ALU  = 2'd1, // alu result from execute
        WB_LINK = 2'd2, // pc + 4 for jal / jalr
        WB_LOAD = 2'd3  // extended load data
    } wb_src_t;

    // ********************************************************************
    // rv64 major opcodes
    // ********************************************************************
    localparam logic [`OPCODE_BITS-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [`OPCODE_BITS-1:0] OP_STORE  = 7'b0100011;
    localparam logic [`OPCODE_BITS-1:0] OP_IMM    = 7'b0010011;
    localparam logic [`OPCODE_BITS-1:0] OP_IMM_32 = 7'b0011011;  // addiw etc
    localparam logic [`OPCODE_BITS-1:0] OP        = 7'b0110011;
    localparam logic [`OPCODE_BITS-1:0] OP_32     = 7'b0111011;  // addw etc
    localparam logic [`OPCODE_BITS-1:0] LUI       = 7'b0110111;
    localparam logic [`OPCODE_BITS-1:0] AUIPC     = 7'b0010111;
    localparam logic [`OPCODE_BITS-1:0] JAL       = 7'b1101111;
    localparam logic [`OPCODE_BITS-1:0] JALR      = 7'b1100111;

    // branches, fences and system ops fall through to WB_NONE

endpackage

/* design/mem_decode.sv */
// instruction class decoder
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_decode (
    input  logic [31:0]              inst,
    output logic                     is_load,
    output logic                     is_store,
    output logic                     writes_rd,
    output mem_stage_pkg::mem_size_t size,
    output logic                     is_unsigned,
    output mem_stage_pkg::wb_src_t   wb_src
);

    logic [`OPCODE_BITS-1:0] opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic                    alu_op;    // legal rd-producing alu / mul op

    assign opcode = inst[`OPCODE_BITS-1:0];
    assign funct3 = inst[`FUNCT3_LSB +: 3];
    assign funct7 = inst[31:25];

    // ********************************************************************
    // alu, m-extension and upper-immediate sets
    // ********************************************************************
    always_comb begin
        alu_op = 1'b0;
        case (opcode)
            mem_stage_pkg::OP_IMM: begin
                case (funct3)
                    3'b001:  alu_op = (funct7[6:1] == 6'b000000);   // slli, 6-bit shamt
                    3'b101:  alu_op = (funct7[6:1] == 6'b000000) ||
                                      (funct7[6:1] == 6'b010000);   // srli / srai
                    default: alu_op = 1'b1;                         // addi .. andi
                endcase
            end
            mem_stage_pkg::OP_IMM_32: begin
                case (funct3)
                    3'b000:  alu_op = 1'b1;                         // addiw
                    3'b001:  alu_op = (funct7 == 7'b0000000);       // slliw
                    3'b101:  alu_op = (funct7 == 7'b0000000) ||
                                      (funct7 == 7'b0100000);       // srliw / sraiw
                    default: alu_op = 1'b0;
                endcase
            end
            mem_stage_pkg::OP: begin
                case (funct7)
                    7'b0000000: alu_op = 1'b1;                      // add .. and
                    7'b0100000: alu_op = (funct3 == 3'b000) ||
                                         (funct3 == 3'b101);        // sub, sra
                    7'b0000001: alu_op = 1'b1;                      // full mul/div set
                    default:    alu_op = 1'b0;
                endcase
            end
            mem_stage_pkg::OP_32: begin
                case (funct7)
                    7'b0000000: alu_op = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                         (funct3 == 3'b101);        // addw sllw srlw
                    7'b0100000: alu_op = (funct3 == 3'b000) ||
                                         (funct3 == 3'b101);        // subw sraw
                    7'b0000001: alu_op = (funct3 == 3'b000) ||
                                         (funct3[2] == 1'b1);       // mulw, divw..remuw
                    default:    alu_op = 1'b0;
                endcase
            end
            mem_stage_pkg::LUI,
            mem_stage_pkg::AUIPC: alu_op = 1'b1;
            default:              alu_op = 1'b0;
        endcase
    end

    // ********************************************************************
    // final classification
    // ********************************************************************
    always_comb begin
        is_load     = 1'b0;
        is_store    = 1'b0;
        writes_rd   = 1'b0;
        size        = mem_stage_pkg::SIZE_B;
        is_unsigned = 1'b0;
        wb_src      = mem_stage_pkg::WB_NONE;
        if (opcode == mem_stage_pkg::OP_LOAD && funct3 != 3'b111) begin
            is_load     = 1'b1;
            writes_rd   = 1'b1;
            size        = mem_stage_pkg::mem_size_t'(funct3[1:0]);
            is_unsigned = funct3[2];                // lbu lhu lwu
            wb_src      = mem_stage_pkg::WB_LOAD;
        end else if (opcode == mem_stage_pkg::OP_STORE && !funct3[2]) begin
            is_store = 1'b1;                        // sb sh sw sd
            size     = mem_stage_pkg::mem_size_t'(funct3[1:0]);
        end else if (opcode == mem_stage_pkg::JAL ||
                     (opcode == mem_stage_pkg::JALR && funct3 == 3'b000)) begin
            writes_rd = 1'b1;
            wb_src    = mem_stage_pkg::WB_LINK;     // link register gets pc+4
        end else if (alu_op) begin
            writes_rd = 1'b1;
            wb_src    = mem_stage_pkg::WB_ALU;
        end
    end

endmodule

/* design/store_align.sv */
// store lane and mask builder
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module store_align (
    input  logic [2:0]               addr_low,  // byte offset in the word
    input  mem_stage_pkg::mem_size_t size,
    input  logic [`XLEN-1:0]         data,      // rs2 value, low bytes used
    output logic [`XLEN-1:0]         lane_data,
    output logic [7:0]               mask
);

    logic [7:0]       base_mask;    // mask before the lane shift
    logic [`XLEN-1:0] sized;        // data with bytes outside the access cleared

    always_comb begin
        case (size)
            mem_stage_pkg::SIZE_B: base_mask = 8'h01;
            mem_stage_pkg::SIZE_H: base_mask = 8'h03;
            mem_stage_pkg::SIZE_W: base_mask = 8'h0f;
            default:               base_mask = 8'hff;   // double
        endcase
    end

    // ********************************************************************
    // clear unused bytes, then move into the addressed lane
    // ********************************************************************
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            sized[8*i +: 8] = base_mask[i] ? data[8*i +: 8] : 8'h00;
        end
    end

    // aligned accesses never shift bytes past bit 63
    assign mask      = base_mask << addr_low;
    assign lane_data = sized << {addr_low, 3'b000};

endmodule

/* design/load_align.sv */
// load lane select and extend
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module load_align (
    input  logic [2:0]               addr_low,      // byte offset in the word
    input  mem_stage_pkg::mem_size_t size,
    input  logic                     is_unsigned,   // zero-extend when set
    input  logic [`XLEN-1:0]         word,          // raw ram word
    output logic [`XLEN-1:0]         data
);

    logic [`XLEN-1:0] shifted;  // addressed byte moved down to bit 0
    logic             sign;     // top bit of the access, 0 for unsigned

    assign shifted = word >> {addr_low, 3'b000};

    always_comb begin
        case (size)
            mem_stage_pkg::SIZE_B: sign = shifted[7];
            mem_stage_pkg::SIZE_H: sign = shifted[15];
            default:               sign = shifted[31];
        endcase
        if (is_unsigned) begin
            sign = 1'b0;
        end
    end

    // ********************************************************************
    // extension per size
    // ********************************************************************
    always_comb begin
        case (size)
            mem_stage_pkg::SIZE_B: data = {{(`XLEN-8){sign}}, shifted[7:0]};
            mem_stage_pkg::SIZE_H: data = {{(`XLEN-16){sign}}, shifted[15:0]};
            mem_stage_pkg::SIZE_W: data = {{(`XLEN-32){sign}}, shifted[31:0]};
            default:               data = shifted;      // ld passes through
        endcase
    end

endmodule

/* design/data_ram.sv */
// byte-masked data ram
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module data_ram (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_req,    // read this cycle
    input  logic                      rd_taken,  // consumer has the data
    input  logic [`RAM_ADDR_BITS-1:0] rd_index,
    input  logic                      wr_en,
    input  logic [`RAM_ADDR_BITS-1:0] wr_index,
    input  logic [`XLEN-1:0]          wr_data,
    input  logic [7:0]                wr_mask,   // one bit per byte lane
    output logic [`XLEN-1:0]          rdata,
    output logic                      rvalid
);

    logic [`XLEN-1:0] mem [0:(1 << `RAM_ADDR_BITS)-1];

    // ********************************************************************
    // write port, byte lanes
    // ********************************************************************
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (wr_en && wr_mask[i]) begin
                mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    // registered read, refreshed every requested cycle
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rdata <= mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_taken) begin
            rvalid <= 1'b0;     // take wins over a new request
        end else if (rd_req) begin
            rvalid <= 1'b1;
        end
    end

endmodule

/* design/mem_stage.sv */
// rv64 memory access stage
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    // from execute
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [`XLEN-1:0] pc_in,
    input  logic [31:0]      inst_in,
    input  logic [`XLEN-1:0] alu_result_in,
    input  logic [`XLEN-1:0] rs2_data_in,
    // to write-back
    output logic             valid_out,
    input  logic             ready_out,
    output logic [`XLEN-1:0] pc_out,
    output logic [31:0]      inst_out,
    output logic             rd_we,
    output logic [4:0]       rd_addr,
    output logic [`XLEN-1:0] rd_wdata,
    // write-back stage contents, for store forwarding
    input  logic             wb_valid,
    input  logic [31:0]      wb_inst,
    input  logic [`XLEN-1:0] wb_wdata
);

    localparam logic [`XLEN-1:0] LINK_OFS = 4;  // jal / jalr return offset

    logic             reg_valid;
    logic [`XLEN-1:0] reg_pc;
    logic [31:0]      reg_inst;
    logic [`XLEN-1:0] reg_alu;      // also the load / store address
    logic [`XLEN-1:0] reg_rs2;

    logic                      is_load, is_store, writes_rd, is_unsigned;
    mem_stage_pkg::mem_size_t  size;
    mem_stage_pkg::wb_src_t    wb_src;
    logic                      wb_writes_rd;

    logic                      blocked;
    logic                      out_en;
    logic                      fwd_hit;
    logic [`XLEN-1:0]          store_data;
    logic [`XLEN-1:0]          lane_data;
    logic [7:0]                lane_mask;
    logic [`XLEN-1:0]          rdata;
    logic                      rvalid;
    logic [`XLEN-1:0]          load_data;
    logic [`RAM_ADDR_BITS-1:0] word_index;

    // ********************************************************************
    // stage register
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_valid <= 1'b0;
        end else if (ready_in) begin
            reg_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_in) begin
            reg_pc   <= pc_in;
            reg_inst <= inst_in;
            reg_alu  <= alu_result_in;
            reg_rs2  <= rs2_data_in;
        end
    end

    mem_decode dec_mem (
        .inst        (reg_inst),
        .is_load     (is_load),
        .is_store    (is_store),
        .writes_rd   (writes_rd),
        .size        (size),
        .is_unsigned (is_unsigned),
        .wb_src      (wb_src)
    );

    // ********************************************************************
    // interlock, a load waits one cycle for the ram
    // ********************************************************************
    assign blocked  = reg_valid && is_load && !rvalid;
    assign ready_in = !blocked && ready_out;
    assign out_en   = reg_valid && !blocked;

    // only the producer flag of the write-back instruction matters
    mem_decode dec_wb (
        .inst        (wb_inst),
        .is_load     (),
        .is_store    (),
        .writes_rd   (wb_writes_rd),
        .size        (),
        .is_unsigned (),
        .wb_src      ()
    );

    assign fwd_hit = wb_valid && wb_writes_rd &&
                     (wb_inst[`RD_LSB +: 5] == reg_inst[`RS2_LSB +: 5]) &&
                     (reg_inst[`RS2_LSB +: 5] != 5'd0);    // x0 never forwards
    assign store_data = fwd_hit ? wb_wdata : reg_rs2;

    // ********************************************************************
    // memory access
    // ********************************************************************
    assign word_index = reg_alu[`RAM_ADDR_BITS+2:3];   // 8-byte words

    store_align u_store_align (
        .addr_low  (reg_alu[2:0]),
        .size      (size),
        .data      (store_data),
        .lane_data (lane_data),
        .mask      (lane_mask)
    );

    data_ram u_data_ram (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (reg_valid && is_load),
        .rd_taken (reg_valid && is_load && ready_in),   // load leaves the stage
        .rd_index (word_index),
        .wr_en    (reg_valid && is_store && ready_in),  // write once, on exit
        .wr_index (word_index),
        .wr_data  (lane_data),
        .wr_mask  (lane_mask),
        .rdata    (rdata),
        .rvalid   (rvalid)
    );

    load_align u_load_align (
        .addr_low    (reg_alu[2:0]),
        .size        (size),
        .is_unsigned (is_unsigned),
        .word        (rdata),
        .data        (load_data)
    );

    // ********************************************************************
    // outputs, zero while blocked or empty
    // ********************************************************************
    assign valid_out = out_en;
    assign pc_out    = out_en ? reg_pc : '0;
    assign inst_out  = out_en ? reg_inst : '0;
    assign rd_we     = out_en && writes_rd;
    assign rd_addr   = out_en ? reg_inst[`RD_LSB +: 5] : 5'd0;

    always_comb begin
        rd_wdata = '0;
        if (out_en) begin
            case (wb_src)
                mem_stage_pkg::WB_ALU:  rd_wdata = reg_alu;
                mem_stage_pkg::WB_LINK: rd_wdata = reg_pc + LINK_OFS;
                mem_stage_pkg::WB_LOAD: rd_wdata = load_data;
                default:                rd_wdata = '0;     // stores, branches
            endcase
        end
    end

endmodule

/* tb/mem_stage_assertions.sv */
// memory stage protocol checks
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_stage_assertions (
    input logic             clk,
    input logic             rst,
    input logic             ready_out,
    input logic             ready_in,
    input logic             valid_in,
    input logic [31:0]      inst_in,
    input logic             valid_out,
    input logic             ram_we,     // store write strobe into the ram
    input logic [`XLEN-1:0] pc_out,
    input logic [`XLEN-1:0] rd_wdata,
    input logic [31:0]      inst_out
);

    // held item must not move or change under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        valid_out && !ready_out |=> valid_out && $stable(pc_out) &&
                                    $stable(inst_out) && $stable(rd_wdata))
        else $error("output changed while ready_out was low");

    // the ram takes a store only at the edge where it leaves
    assert property (@(posedge clk) disable iff (rst)
        ram_we |-> ready_out && valid_out &&
                   inst_out[`OPCODE_BITS-1:0] == mem_stage_pkg::OP_STORE)
        else $error("ram write while ready_out was low or with no store leaving");

    // accepted load stalls one cycle, then its result comes out
    assert property (@(posedge clk) disable iff (rst)
        valid_in && ready_in && inst_in[`OPCODE_BITS-1:0] == mem_stage_pkg::OP_LOAD &&
        inst_in[14:12] != 3'b111 |=> !ready_in && !valid_out ##1 valid_out)
        else $error("ready_in high or no result while a load waited for the ram");

endmodule

bind mem_stage mem_stage_assertions u_checks (
    .clk       (clk),
    .rst       (rst),
    .ready_out (ready_out),
    .ready_in  (ready_in),
    .valid_in  (valid_in),
    .inst_in   (inst_in),
    .valid_out (valid_out),
    .ram_we    (reg_valid && is_store && ready_in),
    .pc_out    (pc_out),
    .rd_wdata  (rd_wdata),
    .inst_out  (inst_out)
);

/* tb/mem_stage_tb.sv */
// memory stage testbench
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_stage_tb;

    localparam int N_ALU  = 40;
    localparam int N_FILL = 32;     // one sd per word of the test region
    localparam int N_MEM  = 60;     // store / load pairs
    localparam int N_FWD  = 10;
    localparam int N_BP   = 60;
    localparam int N_ISSUE = N_ALU + N_FILL + 2 * N_MEM + 3 * (N_FWD + 1) + N_BP;
    localparam int LIMIT   = 4 * N_ISSUE + 100;    // 100 spare covers reset

    logic             clk = 1'b0;
    logic             rst, valid_in, ready_in, valid_out, rd_we;
    logic             ready_out = 1'b1;
    logic             wb_valid = 1'b0;
    logic [`XLEN-1:0] pc_in, alu_result_in, rs2_data_in, pc_out, rd_wdata;
    logic [`XLEN-1:0] wb_wdata = '0;
    logic [31:0]      inst_in, inst_out;
    logic [31:0]      wb_inst = '0;
    logic [4:0]       rd_addr;

    logic        bp_on = 1'b1;      // random back-pressure enable
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cur_test = 0;
    int          test_err [5];
    string       test_name [5] = '{"reset", "alu and link", "loads and stores",
                                   "store forwarding", "back-pressure"};
    logic [7:0]  shadow [0:263];    // byte image of the first 32 words
    logic [63:0] next_pc = 64'h1000;
    logic [31:0] prev_inst;         // last issued, what write-back will hold
    logic [63:0] prev_wdata;
    logic        have_prev = 1'b0;
    logic [31:0] q_inst [$];
    logic [63:0] q_pc [$];
    logic        q_we [$];
    logic [63:0] q_wdata [$];
    int          q_test [$];

    mem_stage DUT (.*);

    always #50 clk = ~clk;

    // ******************************************************************
    // reference model
    // ******************************************************************
    function automatic logic is_producer(input logic [31:0] inst);
        logic [6:0] op;
        op = inst[6:0];
        return op == mem_stage_pkg::OP_LOAD || op == mem_stage_pkg::OP_IMM ||
               op == mem_stage_pkg::OP_IMM_32 || op == mem_stage_pkg::OP ||
               op == mem_stage_pkg::OP_32 || op == mem_stage_pkg::LUI ||
               op == mem_stage_pkg::AUIPC || op == mem_stage_pkg::JAL ||
               op == mem_stage_pkg::JALR;
    endfunction

    function automatic logic [63:0] expected_wdata(input logic [31:0] inst,
                                                   input logic [63:0] pc, alu, raw);
        logic s;
        s = ~inst[14];      // signed unless funct3[2]
        if (inst[6:0] == mem_stage_pkg::OP_LOAD) begin
            case (inst[13:12])
                2'd0:    return {{56{s & raw[7]}}, raw[7:0]};
                2'd1:    return {{48{s & raw[15]}}, raw[15:0]};
                2'd2:    return {{32{s & raw[31]}}, raw[31:0]};
                default: return raw;
            endcase
        end
        if (inst[6:0] == mem_stage_pkg::JAL || inst[6:0] == mem_stage_pkg::JALR)
            return pc + 64'd4;
        return is_producer(inst) ? alu : 64'd0;     // stores and branches write nothing
    endfunction

    // store data as the write-back stage would forward it
    function automatic logic [63:0] store_value(input logic [31:0] inst, input logic [63:0] rs2);
        if (have_prev && is_producer(prev_inst) && prev_inst[11:7] == inst[24:20] &&
            inst[24:20] != 5'd0)
            return prev_wdata;
        return rs2;
    endfunction

    function automatic logic [63:0] read_shadow(input int a);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) v[8*i +: 8] = shadow[a + i];
        return v;
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs2);
        return {7'b0, rs2, 5'd1, f3, rd, op};    // rs1 fixed at x1
    endfunction

    function automatic logic [63:0] rand_addr(input logic [1:0] size);
        logic [2:0] off;
        off = 3'($urandom % 8) & ~3'((1 << size) - 1);  // natural alignment
        return {56'd0, 5'($urandom % 32), off};
    endfunction

    // ******************************************************************
    // stimulus
    // ******************************************************************
    task automatic issue(input logic [31:0] inst, input logic [63:0] alu, rs2);
        logic [63:0] pc;
        logic [63:0] sval;
        int          a;
        pc = next_pc;
        next_pc += 64'd4;
        valid_in      <= 1'b1;
        pc_in         <= pc;
        inst_in       <= inst;
        alu_result_in <= alu;
        rs2_data_in   <= rs2;
        @(posedge clk);
        while (!ready_in) @(posedge clk);   // accepted at this edge
        a = int'(alu[7:0]);
        if (inst[6:0] == mem_stage_pkg::OP_STORE) begin
            sval = store_value(inst, rs2);
            for (int i = 0; i < (1 << inst[13:12]); i++) shadow[a + i] = sval[8*i +: 8];
        end
        q_inst.push_back(inst);
        q_pc.push_back(pc);
        q_we.push_back(is_producer(inst));
        q_wdata.push_back(expected_wdata(inst, pc, alu, read_shadow(a)));
        q_test.push_back(cur_test);
        prev_inst  = inst;
        prev_wdata = q_wdata[$];
        have_prev  = 1'b1;
    endtask

    task automatic random_alu();
        logic [6:0] ops [7];
        logic [6:0] op;
        logic [2:0] f3;
        ops = '{mem_stage_pkg::OP, mem_stage_pkg::OP_IMM, mem_stage_pkg::LUI,
                mem_stage_pkg::AUIPC, mem_stage_pkg::JAL, mem_stage_pkg::JALR, 7'b1100011};
        op = ops[$urandom % 7];
        f3 = (op == mem_stage_pkg::JALR) ? 3'd0 : 3'($urandom % 8);    // jalr needs 000
        issue(encode(op, 5'(1 + $urandom % 31), f3, 5'($urandom)),
              {$urandom, $urandom}, {$urandom, $urandom});
    endtask

    task automatic random_store(output logic [63:0] addr);
        logic [1:0] size;
        size = 2'($urandom % 4);
        addr = rand_addr(size);
        issue(encode(mem_stage_pkg::OP_STORE, 5'd0, {1'b0, size}, 5'($urandom)),
              addr, {$urandom, $urandom});
    endtask

    task automatic random_load(input logic [63:0] near);
        logic [1:0]  size;
        logic        uns;
        logic [63:0] offs;
        size = 2'($urandom % 4);
        uns  = (size != 2'd3) ? 1'($urandom % 2) : 1'b0;  // no ldu
        offs = rand_addr(size);
        issue(encode(mem_stage_pkg::OP_LOAD, 5'(1 + $urandom % 31), {uns, size}, 5'd0),
              {near[63:3], offs[2:0]}, 64'd0);
    endtask

    task automatic finish_test();
        valid_in <= 1'b0;
        while (q_inst.size() != 0) @(posedge clk);
        if (test_err[cur_test] == 0) $display("%s: pass", test_name[cur_test]);
        else $display("%s: %0d mismatches", test_name[cur_test], test_err[cur_test]);
        cur_test++;
    endtask

    // ******************************************************************
    // write-back model, back-pressure, compare, timeout
    // ******************************************************************
    always @(posedge clk) begin
        if (rst) wb_valid <= 1'b0;
        else if (valid_out && ready_out) begin  // write-back holds its last item
            wb_valid <= 1'b1;
            wb_inst  <= inst_out;
            wb_wdata <= rd_wdata;
        end
    end

    always @(posedge clk) ready_out <= bp_on ? ($urandom % 3 != 0) : 1'b1;

    task automatic note_fail(input int t);
        errors++;
        test_err[t]++;
    endtask

    // idle outputs during and right after reset
    task automatic check_idle_outputs();
        assert (valid_out === 1'b0 && rd_we === 1'b0 && ready_in === ready_out) else begin
            $display("FAILED %s valid_out/rd_we/ready_in expected 0/0/%b actual %b/%b/%b",
                     test_name[0], ready_out, valid_out, rd_we, ready_in);
            note_fail(0);
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] e_inst;
        logic [63:0] e_pc;
        logic        e_we;
        logic [63:0] e_wdata;
        int          t;
        if (!rst && valid_out && ready_out) begin
            if (q_inst.size() == 0) begin
                $display("output taken with nothing pending, inst %h", inst_out);
                note_fail(cur_test);
            end else begin
                e_inst  = q_inst.pop_front();
                e_pc    = q_pc.pop_front();
                e_we    = q_we.pop_front();
                e_wdata = q_wdata.pop_front();
                t       = q_test.pop_front();
                checks++;
                assert (inst_out === e_inst) else begin
                    $display("FAILED %s inst expected %h actual %h", test_name[t],
                             e_inst, inst_out);
                    note_fail(t);
                end
                assert (pc_out === e_pc) else begin
                    $display("FAILED %s pc_out expected %h actual %h", test_name[t],
                             e_pc, pc_out);
                    note_fail(t);
                end
                assert (rd_we === e_we && rd_addr === e_inst[11:7]) else begin
                    $display("FAILED %s we/rd expected %b/%0d actual %b/%0d", test_name[t],
                             e_we, e_inst[11:7], rd_we, rd_addr);
                    note_fail(t);
                end
                assert (rd_wdata === e_wdata) else begin
                    $display("FAILED %s rd_wdata expected %h actual %h", test_name[t],
                             e_wdata, rd_wdata);
                    note_fail(t);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout, the run did not finish in %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // ******************************************************************
    // test sequence
    // ******************************************************************
    initial begin
        logic [63:0] addr;
        logic [4:0]  r;
        void'($urandom(34840));
        rst           <= 1'b1;
        valid_in      <= 1'b0;
        pc_in         <= '0;
        inst_in       <= '0;
        alu_result_in <= '0;
        rs2_data_in   <= '0;
        for (int i = 0; i < 5; i++) test_err[i] = 0;
        for (int i = 0; i < 8; i++) begin       // 8 reset cycles, checked from the second
            @(posedge clk);
            if (i == 7) rst <= 1'b0;
            if (i > 0) check_idle_outputs();
        end
        @(posedge clk);
        check_idle_outputs();                   // first cycle out of reset
        bp_on <= 1'b0;
        finish_test();
        for (int i = 0; i < N_ALU; i++) random_alu();
        finish_test();
        for (int w = 0; w < N_FILL; w++)        // defined contents for the loads
            issue(encode(mem_stage_pkg::OP_STORE, 5'd0, 3'd3, 5'd0), 64'(w * 8),
                  {$urandom, $urandom});
        for (int i = 0; i < N_MEM; i++) begin
            random_store(addr);
            random_load(addr);
        end
        finish_test();
        for (int i = 0; i <= N_FWD; i++) begin
            r = (i == N_FWD) ? 5'd0 : 5'(1 + $urandom % 31);     // last round uses x0
            addr = rand_addr(2'd3);
            issue(encode(mem_stage_pkg::OP_IMM, r, 3'd0, 5'd0), {$urandom, $urandom}, 64'd0);
            issue(encode(mem_stage_pkg::OP_STORE, 5'd0, 3'd3, r), addr, {$urandom, $urandom});
            issue(encode(mem_stage_pkg::OP_LOAD, 5'd9, 3'd3, 5'd0), addr, 64'd0);
        end
        finish_test();
        bp_on <= 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            case ($urandom % 3)
                0:       random_alu();
                1:       random_store(addr);
                default: random_load(rand_addr(2'd3));
            endcase
        end
        finish_test();
        $display("tests 5, checks %0d, mismatches %0d", checks, errors);
        if (errors == 0) $display("No errors");
        else $display("Errors found");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/mem_stage_pkg.sv
design/mem_decode.sv
design/store_align.sv
design/load_align.sv
design/data_ram.sv
design/mem_stage.sv
tb/mem_stage_assertions.sv
tb/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module mem_stage_tb -o mem_stage_sim
./obj_dir/mem_stage_sim > sim.log 2>&1 || true
cat sim.log
grep -q "No errors" sim.log
